//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the back-end testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f src.f \
    --top-module tb_ooo_backend -o Vtb_ooo_backend

./obj_dir/Vtb_ooo_backend | tee "$LOG"

if grep -q "Done: errors found" "$LOG"; then
    echo "Simulation FAILED"
    exit 1
fi
if ! grep -q "Done: no errors" "$LOG"; then
    echo "Simulation ended without a verdict"
    exit 1
fi
echo "Simulation PASSED"

//--- source/backend_defines.svh
`ifndef BACKEND_DEFINES_SVH
`define BACKEND_DEFINES_SVH

// --------------------------------------------------------------------------
// Back-end sizing
// --------------------------------------------------------------------------

`define BE_XLEN      32     // Data path width
`define BE_NREGS     16     // Architectural registers, r0 reads as zero

// Reorder buffer geometry
`define BE_ROB_DEPTH 8
`define BE_ROB_IDX_W 3      // log2 of the ROB depth

`define BE_MUL_LAT   3      // Multiplier pipeline stages

`endif

//--- source/backend_pkg.sv
`include "backend_defines.svh"

package backend_pkg;

    typedef logic [`BE_XLEN-1:0]      word_t;
    typedef logic [`BE_ROB_IDX_W-1:0] rob_idx_t;

    // --------------------------------------------------------------------------
    // Host side
    // --------------------------------------------------------------------------

    typedef struct packed {
        isa_pkg::instr_t        instr;
        word_t                  pc;
    } issue_req_t;

    // Decode to execute
    typedef struct packed {
        logic                   sel_mul;        // 1 selects the multiplier
        isa_pkg::opcode_t       op;
        word_t                  opa;
        word_t                  opb;            // rs2 or the ADDI immediate
        rob_idx_t               rob_idx;        // Destination entry
    } exec_req_t;

    // Result broadcast on the CDB
    typedef struct packed {
        rob_idx_t               rob_idx;
        word_t                  value;
        logic                   except_raised;
        isa_pkg::except_code_t  except_code;
    } cdb_data_t;

    // --------------------------------------------------------------------------
    // ROB storage and commit
    // --------------------------------------------------------------------------

    typedef struct packed {
        logic                   valid;
        logic                   res_ready;      // Result present, may commit
        isa_pkg::instr_t        instr;
        word_t                  pc;
        isa_pkg::reg_idx_t      rd;
        word_t                  res_value;
        logic                   except_raised;
        isa_pkg::except_code_t  except_code;
    } rob_entry_t;

    typedef struct packed {
        rob_idx_t               rob_idx;        // Entry leaving the head
        word_t                  pc;
        isa_pkg::reg_idx_t      rd;
        word_t                  value;
        logic                   except_raised;
        isa_pkg::except_code_t  except_code;
    } commit_t;

endpackage

//--- source/exec_units.sv
`timescale 1ns/10ps
`include "backend_defines.svh"

module exec_units (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  logic                        flush_i,
    input  logic                        exec_valid_i,
    input  backend_pkg::exec_req_t      exec_i,
    output logic                        mul_slot_busy_o,
    output logic                        cdb_valid_o,
    output backend_pkg::cdb_data_t      cdb_o
);

    localparam int LAT = `BE_MUL_LAT;

    logic                   alu_vld_q;
    logic [`BE_XLEN-1:0]    alu_res_q;
    backend_pkg::rob_idx_t  alu_idx_q;
    logic [LAT-1:0]         mul_vld_q;              // One bit per stage
    logic [`BE_XLEN-1:0]    mul_res_q [LAT];
    backend_pkg::rob_idx_t  mul_idx_q [LAT];
    logic [`BE_XLEN-1:0]    alu_res;

    // --------------------------------------------------------------------------
    // ALU, one registered stage
    // --------------------------------------------------------------------------
    always_comb begin
        case (exec_i.op)
            isa_pkg::OP_SUB: alu_res = exec_i.opa - exec_i.opb;
            isa_pkg::OP_XOR: alu_res = exec_i.opa ^ exec_i.opb;
            default:         alu_res = exec_i.opa + exec_i.opb;   // ADD and ADDI
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            alu_vld_q <= 1'b0;
            mul_vld_q <= '0;
        end else if (flush_i) begin
            alu_vld_q <= 1'b0;
            mul_vld_q <= '0;                    // Drop every product in flight
        end else begin
            alu_vld_q <= exec_valid_i && !exec_i.sel_mul;
            mul_vld_q <= {mul_vld_q[LAT-2:0], exec_valid_i && exec_i.sel_mul};
        end
    end

    // Payload path, multiply in stage 0 and carry the product along
    always_ff @(posedge clk_i) begin
        alu_res_q    <= alu_res;
        alu_idx_q    <= exec_i.rob_idx;
        mul_res_q[0] <= exec_i.opa * exec_i.opb;
        mul_idx_q[0] <= exec_i.rob_idx;
        for (int s = 1; s < LAT; s++) begin
            mul_res_q[s] <= mul_res_q[s-1];
            mul_idx_q[s] <= mul_idx_q[s-1];
        end
    end

    // --------------------------------------------------------------------------
    // CDB driver
    // --------------------------------------------------------------------------
    assign mul_slot_busy_o = mul_vld_q[LAT-2];     // Finishes next cycle
    assign cdb_valid_o     = alu_vld_q || mul_vld_q[LAT-1];

    always_comb begin
        cdb_o.except_raised = 1'b0;                 // Units raise no exceptions
        cdb_o.except_code   = isa_pkg::E_NONE;
        if (mul_vld_q[LAT-1]) begin
            cdb_o.rob_idx = mul_idx_q[LAT-1];
            cdb_o.value   = mul_res_q[LAT-1];
        end else begin
            cdb_o.rob_idx = alu_idx_q;
            cdb_o.value   = alu_res_q;
        end
    end

    a_one_finisher: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(alu_vld_q && mul_vld_q[LAT-1]))
        else $error("ALU and multiplier finish in the same cycle");

    a_known_op: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        exec_valid_i |-> !$isunknown(exec_i.op) && exec_i.op inside
            {isa_pkg::OP_ADD, isa_pkg::OP_SUB, isa_pkg::OP_XOR, isa_pkg::OP_ADDI,
             isa_pkg::OP_MUL})
        else $error("Execute request with an unknown op");

endmodule

//--- source/isa_pkg.sv
`include "backend_defines.svh"

package isa_pkg;

    // Register specifier, 4 bits for 16 registers
    typedef logic [$clog2(`BE_NREGS)-1:0] reg_idx_t;

    // Opcodes of the small ISA; every other code is illegal
    typedef enum logic [3:0] {
        OP_ADD  = 4'h0,
        OP_SUB  = 4'h1,
        OP_XOR  = 4'h2,
        OP_ADDI = 4'h3,     // rd = rs1 + sext(imm)
        OP_LI   = 4'h4,     // rd = sext(imm), resolved at issue
        OP_MUL  = 4'h5      // Low half of the product
    } opcode_t;

    // 32-bit instruction word
    typedef struct packed {
        opcode_t        op;
        reg_idx_t       rd;
        reg_idx_t       rs1;
        reg_idx_t       rs2;
        logic [15:0]    imm;
    } instr_t;

    typedef enum logic [3:0] {
        E_NONE          = 4'h0,
        E_ILLEGAL_INSTR = 4'h2
    } except_code_t;

    // Opcode decode shared by issue and ROB
    function automatic logic op_legal(opcode_t op);
        return op inside {OP_ADD, OP_SUB, OP_XOR, OP_ADDI, OP_LI, OP_MUL};
    endfunction

    function automatic logic [`BE_XLEN-1:0] imm_sext(logic [15:0] imm);
        return {{(`BE_XLEN-16){imm[15]}}, imm};
    endfunction

endpackage

//--- source/issue_decode.sv
`timescale 1ns/10ps
`include "backend_defines.svh"

module issue_decode (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  logic                        flush_i,
    input  logic                        issue_valid_i,
    output logic                        issue_ready_o,
    input  backend_pkg::issue_req_t     issue_i,
    input  logic                        rob_ready_i,        // Tail entry free
    input  backend_pkg::rob_idx_t       rob_tail_idx_i,
    output logic                        rob_alloc_o,
    output backend_pkg::rob_idx_t       rs1_rob_idx_o,
    output backend_pkg::rob_idx_t       rs2_rob_idx_o,
    input  logic                        rs1_ready_i,
    input  logic [`BE_XLEN-1:0]         rs1_value_i,
    input  logic                        rs2_ready_i,
    input  logic [`BE_XLEN-1:0]         rs2_value_i,
    input  logic                        mul_slot_busy_i,    // ALU result would collide
    output logic                        exec_valid_o,
    output backend_pkg::exec_req_t      exec_o,
    input  logic                        comm_fire_i,
    input  backend_pkg::commit_t        comm_i
);

    logic [`BE_XLEN-1:0]    rf_q [`BE_NREGS];       // Architectural registers
    logic [`BE_NREGS-1:0]   busy_q;                 // Writer still in flight
    backend_pkg::rob_idx_t  owner_q [`BE_NREGS];    // Youngest writer's entry
    isa_pkg::instr_t        ins;
    logic                   legal, is_mul, is_alu, use_rs1, use_rs2;
    logic                   rs1_ok, rs2_ok, unit_ok, fire;
    logic [`BE_XLEN-1:0]    rs1_val, rs2_val;

    // --------------------------------------------------------------------------
    // Decode and operand selection
    // --------------------------------------------------------------------------
    assign ins     = issue_i.instr;
    assign legal   = isa_pkg::op_legal(ins.op);
    assign is_mul  = (ins.op == isa_pkg::OP_MUL);
    assign is_alu  = legal && !is_mul && (ins.op != isa_pkg::OP_LI);
    assign use_rs1 = is_alu || is_mul;
    assign use_rs2 = is_mul || (is_alu && ins.op != isa_pkg::OP_ADDI);

    assign rs1_rob_idx_o = owner_q[ins.rs1];   // ROB read ports follow the table
    assign rs2_rob_idx_o = owner_q[ins.rs2];

    always_comb begin
        rs1_ok = !use_rs1 || !busy_q[ins.rs1] || rs1_ready_i;
        rs2_ok = !use_rs2 || !busy_q[ins.rs2] || rs2_ready_i;
        // r0 is never marked busy, so the forward check comes first
        if (busy_q[ins.rs1]) rs1_val = rs1_value_i;
        else if (ins.rs1 == '0) rs1_val = '0;
        else rs1_val = rf_q[ins.rs1];
        if (busy_q[ins.rs2]) rs2_val = rs2_value_i;
        else if (ins.rs2 == '0) rs2_val = '0;
        else rs2_val = rf_q[ins.rs2];
    end

    // --------------------------------------------------------------------------
    // Issue handshake and dispatch
    // --------------------------------------------------------------------------
    assign unit_ok       = !(is_alu && mul_slot_busy_i);  // MUL takes one per cycle
    assign issue_ready_o = rob_ready_i && rs1_ok && rs2_ok && unit_ok && !flush_i;
    assign fire          = issue_valid_i && issue_ready_o;
    assign rob_alloc_o   = fire;
    assign exec_valid_o  = fire && (is_alu || is_mul);     // LI and illegal skip execute

    always_comb begin
        exec_o.sel_mul = is_mul;
        exec_o.op      = ins.op;
        exec_o.opa     = rs1_val;
        exec_o.opb     = (ins.op == isa_pkg::OP_ADDI) ? isa_pkg::imm_sext(ins.imm) : rs2_val;
        exec_o.rob_idx = rob_tail_idx_i;
    end

    // --------------------------------------------------------------------------
    // Register status and register file
    // --------------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            busy_q <= '0;
        end else if (flush_i) begin
            busy_q <= '0;                   // Nothing left in flight
        end else begin
            // Only the writer named in the table releases the register
            if (comm_fire_i && owner_q[comm_i.rd] == comm_i.rob_idx)
                busy_q[comm_i.rd] <= 1'b0;
            if (fire && legal && ins.rd != '0)
                busy_q[ins.rd] <= 1'b1;     // Same-cycle allocation wins
        end
    end

    always_ff @(posedge clk_i) begin
        if (fire && legal)
            owner_q[ins.rd] <= rob_tail_idx_i;
        if (comm_fire_i && !comm_i.except_raised && comm_i.rd != '0)
            rf_q[comm_i.rd] <= comm_i.value;   // Write-back at commit
    end

    // A busy register always names a live entry, never the free tail
    a_tail_not_owner: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        rob_alloc_o |-> !(busy_q[ins.rd] && owner_q[ins.rd] == rob_tail_idx_i))
        else $error("Allocated ROB entry is still named in the status table");

endmodule

//--- source/ooo_backend.sv
`timescale 1ns/10ps
`include "backend_defines.svh"

module ooo_backend (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  logic                        flush_i,
    input  logic                        issue_valid_i,
    output logic                        issue_ready_o,
    input  backend_pkg::issue_req_t     issue_i,
    output logic                        comm_valid_o,
    input  logic                        comm_ready_i,
    output backend_pkg::commit_t        comm_o
);

    logic                       rob_ready, rob_alloc, comm_fire;
    backend_pkg::rob_idx_t      tail_idx, rs1_idx, rs2_idx;
    logic                       rs1_ready, rs2_ready;
    logic [`BE_XLEN-1:0]        rs1_value, rs2_value;
    logic                       exec_valid, mul_slot_busy, cdb_valid;
    backend_pkg::exec_req_t     exec_req;
    backend_pkg::cdb_data_t     cdb;

    // --------------------------------------------------------------------------
    // Decode, execute and reorder stages
    // --------------------------------------------------------------------------
    issue_decode u_decode (
        .clk_i, .rst_n_i, .flush_i,
        .issue_valid_i, .issue_ready_o, .issue_i,
        .rob_ready_i     (rob_ready),
        .rob_tail_idx_i  (tail_idx),
        .rob_alloc_o     (rob_alloc),
        .rs1_rob_idx_o   (rs1_idx),
        .rs2_rob_idx_o   (rs2_idx),
        .rs1_ready_i     (rs1_ready),
        .rs1_value_i     (rs1_value),
        .rs2_ready_i     (rs2_ready),
        .rs2_value_i     (rs2_value),
        .mul_slot_busy_i (mul_slot_busy),
        .exec_valid_o    (exec_valid),
        .exec_o          (exec_req),
        .comm_fire_i     (comm_fire),
        .comm_i          (comm_o)        // Commit write-back
    );

    exec_units u_exec (
        .clk_i, .rst_n_i, .flush_i,
        .exec_valid_i    (exec_valid),
        .exec_i          (exec_req),
        .mul_slot_busy_o (mul_slot_busy),
        .cdb_valid_o     (cdb_valid),
        .cdb_o           (cdb)
    );

    rob u_rob (
        .clk_i, .rst_n_i, .flush_i,
        .alloc_valid_i   (rob_alloc),
        .alloc_i         (issue_i),      // Payload straight from the host
        .alloc_ready_o   (rob_ready),
        .tail_idx_o      (tail_idx),
        .rs1_idx_i       (rs1_idx),
        .rs2_idx_i       (rs2_idx),
        .rs1_ready_o     (rs1_ready),
        .rs1_value_o     (rs1_value),
        .rs2_ready_o     (rs2_ready),
        .rs2_value_o     (rs2_value),
        .cdb_valid_i     (cdb_valid),
        .cdb_i           (cdb),
        .comm_ready_i, .comm_valid_o, .comm_o,
        .comm_fire_o     (comm_fire)
    );

endmodule

//--- source/rob.sv
`timescale 1ns/10ps
`include "backend_defines.svh"

module rob (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  logic                        flush_i,
    // Allocation from decode
    input  logic                        alloc_valid_i,
    input  backend_pkg::issue_req_t     alloc_i,
    output logic                        alloc_ready_o,
    output backend_pkg::rob_idx_t       tail_idx_o,
    // Operand read ports
    input  backend_pkg::rob_idx_t       rs1_idx_i,
    input  backend_pkg::rob_idx_t       rs2_idx_i,
    output logic                        rs1_ready_o,
    output logic [`BE_XLEN-1:0]         rs1_value_o,
    output logic                        rs2_ready_o,
    output logic [`BE_XLEN-1:0]         rs2_value_o,
    // Result write, always accepted
    input  logic                        cdb_valid_i,
    input  backend_pkg::cdb_data_t      cdb_i,
    // In-order commit
    input  logic                        comm_ready_i,
    output logic                        comm_valid_o,
    output backend_pkg::commit_t        comm_o,
    output logic                        comm_fire_o
);

    backend_pkg::rob_entry_t    rob_q [`BE_ROB_DEPTH];
    backend_pkg::rob_entry_t    new_ent, head;
    backend_pkg::rob_idx_t      head_q, tail_q, head_nxt, tail_nxt;
    logic                       full, push, legal, is_li;

    // --------------------------------------------------------------------------
    // Control
    // --------------------------------------------------------------------------
    assign head     = rob_q[head_q];
    assign full     = rob_q[tail_q].valid;         // Tail caught up with the head
    assign push     = alloc_valid_i && !full;
    assign head_nxt = (head_q == `BE_ROB_DEPTH-1) ? '0 : head_q + 1'b1;
    assign tail_nxt = (tail_q == `BE_ROB_DEPTH-1) ? '0 : tail_q + 1'b1;

    assign legal = isa_pkg::op_legal(alloc_i.instr.op);
    assign is_li = (alloc_i.instr.op == isa_pkg::OP_LI);

    // New entry, LI and illegal ops are complete on arrival
    always_comb begin
        new_ent.valid         = 1'b1;
        new_ent.res_ready     = is_li || !legal;
        new_ent.instr         = alloc_i.instr;
        new_ent.pc            = alloc_i.pc;
        new_ent.rd            = alloc_i.instr.rd;
        new_ent.res_value     = is_li ? isa_pkg::imm_sext(alloc_i.instr.imm) : '0;
        new_ent.except_raised = !legal;
        if (legal) new_ent.except_code = isa_pkg::E_NONE;
        else new_ent.except_code = isa_pkg::E_ILLEGAL_INSTR;
    end

    // --------------------------------------------------------------------------
    // Entry and pointer update
    // --------------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i || flush_i) begin
            head_q <= '0;
            tail_q <= '0;
            for (int i = 0; i < `BE_ROB_DEPTH; i++) begin
                rob_q[i].valid     <= 1'b0;     // Status bits only
                rob_q[i].res_ready <= 1'b0;
            end
        end else begin
            if (push) begin
                rob_q[tail_q] <= new_ent;
                tail_q        <= tail_nxt;
            end
            if (cdb_valid_i) begin
                rob_q[cdb_i.rob_idx].res_ready     <= 1'b1;
                rob_q[cdb_i.rob_idx].res_value     <= cdb_i.value;
                rob_q[cdb_i.rob_idx].except_raised <= cdb_i.except_raised;
                rob_q[cdb_i.rob_idx].except_code   <= cdb_i.except_code;
            end
            if (comm_fire_o) begin
                rob_q[head_q].valid     <= 1'b0;   // Pop
                rob_q[head_q].res_ready <= 1'b0;
                head_q                  <= head_nxt;
            end
        end
    end

    // --------------------------------------------------------------------------
    // Outputs
    // --------------------------------------------------------------------------
    assign alloc_ready_o = !full;
    assign tail_idx_o    = tail_q;

    assign rs1_ready_o = rob_q[rs1_idx_i].res_ready;
    assign rs1_value_o = rob_q[rs1_idx_i].res_value;
    assign rs2_ready_o = rob_q[rs2_idx_i].res_ready;
    assign rs2_value_o = rob_q[rs2_idx_i].res_value;

    assign comm_valid_o = head.valid && head.res_ready;
    assign comm_fire_o  = comm_valid_o && comm_ready_i;

    always_comb begin
        comm_o.rob_idx       = head_q;
        comm_o.pc            = head.pc;
        comm_o.rd            = head.rd;
        comm_o.value         = head.res_value;
        comm_o.except_raised = head.except_raised;
        comm_o.except_code   = head.except_code;
    end

    a_cdb_live_entry: assert property (@(posedge clk_i) disable iff (!rst_n_i || flush_i)
        cdb_valid_i |-> rob_q[cdb_i.rob_idx].valid)
        else $error("CDB result for an entry that is not allocated");

    a_no_push_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        alloc_valid_i |-> !full)
        else $error("Allocation request while the ROB is full");

endmodule

//--- src.f
+incdir+source
source/isa_pkg.sv
source/backend_pkg.sv
source/issue_decode.sv
source/exec_units.sv
source/rob.sv
source/ooo_backend.sv
verif/commit_checker.sv
verif/tb_ooo_backend.sv

//--- verif/commit_checker.sv
`timescale 1ns/10ps
`include "backend_defines.svh"

module commit_checker (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  logic                        flush_i,
    input  logic                        issue_valid_i,
    input  logic                        issue_ready_i,
    input  backend_pkg::issue_req_t     issue_i,
    input  logic                        comm_valid_i,
    input  logic                        comm_ready_i,
    input  backend_pkg::commit_t        comm_i,
    output int                          pend_o,         // Accepted, not yet committed
    output int                          err_cnt_o,
    output int                          comm_cnt_o
);

    backend_pkg::issue_req_t    exp_q [$];              // Accepted work in program order
    backend_pkg::rob_idx_t      idx_q [$];              // Entry each one was given
    logic [`BE_XLEN-1:0]        arch_q [`BE_NREGS];     // Architectural reference state
    backend_pkg::issue_req_t    head;
    backend_pkg::rob_idx_t      alloc_idx;              // Next tail, circular from zero
    backend_pkg::rob_idx_t      exp_idx;
    logic [`BE_XLEN-1:0]        exp_val;
    logic                       illegal;
    int                         errs = 0;
    int                         comms = 0;

    function automatic logic [`BE_XLEN-1:0] sext16(input logic [15:0] v);
        return {{(`BE_XLEN-16){v[15]}}, v};
    endfunction

    // Sequential ISA semantics on the committed register state
    function automatic logic [`BE_XLEN-1:0] ref_result(input isa_pkg::instr_t ins);
        logic [`BE_XLEN-1:0] a;
        logic [`BE_XLEN-1:0] b;
        a = arch_q[ins.rs1];
        b = arch_q[ins.rs2];
        case (ins.op)
            isa_pkg::OP_ADD:  return a + b;
            isa_pkg::OP_SUB:  return a - b;
            isa_pkg::OP_XOR:  return a ^ b;
            isa_pkg::OP_ADDI: return a + sext16(ins.imm);
            isa_pkg::OP_LI:   return sext16(ins.imm);
            isa_pkg::OP_MUL:  return a * b;         // Low half only
            default:          return '0;            // Illegal op carries zero
        endcase
    endfunction

    // ------------------------------------------------------------------------
    // Port monitor
    // ------------------------------------------------------------------------
    always @(posedge clk_i) begin
        if (!rst_n_i) begin
            exp_q.delete();
            idx_q.delete();
            alloc_idx = '0;
            for (int r = 0; r < `BE_NREGS; r++)
                arch_q[r] = '0;
        end else begin
            // LI needs no operand and no unit, only a free ROB entry
            if (!flush_i && issue_valid_i && !issue_ready_i &&
                issue_i.instr.op == isa_pkg::OP_LI && exp_q.size() < `BE_ROB_DEPTH) begin
                $display("LI held back at %0t although the ROB had a free entry", $time);
                errs++;
            end
            if (comm_valid_i && comm_ready_i) begin
                comms++;
                if (exp_q.size() == 0) begin
                    $display("Commit at %0t with no accepted instruction left", $time);
                    errs++;
                end else begin
                    head    = exp_q.pop_front();
                    exp_idx = idx_q.pop_front();
                    illegal = !(head.instr.op inside {isa_pkg::OP_ADD, isa_pkg::OP_SUB,
                        isa_pkg::OP_XOR, isa_pkg::OP_ADDI, isa_pkg::OP_LI, isa_pkg::OP_MUL});
                    exp_val = ref_result(head.instr);
                    if (comm_i.pc !== head.pc || comm_i.rd !== head.instr.rd ||
                        comm_i.rob_idx !== exp_idx ||
                        comm_i.value !== exp_val || comm_i.except_raised !== illegal ||
                        comm_i.except_code !== (illegal ? isa_pkg::E_ILLEGAL_INSTR
                                                        : isa_pkg::E_NONE)) begin
                        $display("MISMATCH @%0t: pc %h idx %0d rd %0d value %h exc %b/%0d",
                            $time, comm_i.pc, comm_i.rob_idx, comm_i.rd, comm_i.value,
                            comm_i.except_raised, comm_i.except_code);
                        $display("MISMATCH @%0t: expected pc %h %s", $time, head.pc,
                            $sformatf("idx %0d rd %0d value %h exc %b",
                            exp_idx, head.instr.rd, exp_val, illegal));
                        errs++;
                    end
                    if (!illegal && head.instr.rd != '0)
                        arch_q[head.instr.rd] = exp_val;    // r0 stays zero
                end
            end
            if (flush_i) begin
                exp_q.delete();                 // Flushed work never commits
                idx_q.delete();
                alloc_idx = '0;                 // Pointers restart at entry zero
            end else if (issue_valid_i && issue_ready_i) begin
                if (exp_q.size() >= `BE_ROB_DEPTH) begin
                    $display("Instruction accepted at %0t with the ROB already full", $time);
                    errs++;
                end
                exp_q.push_back(issue_i);
                idx_q.push_back(alloc_idx);
                alloc_idx = (alloc_idx == `BE_ROB_DEPTH-1) ? '0 : alloc_idx + 1'b1;
            end
        end
        pend_o     <= exp_q.size();
        err_cnt_o  <= errs;
        comm_cnt_o <= comms;
    end

endmodule

//--- verif/tb_ooo_backend.sv
`timescale 1ns/10ps

module tb_ooo_backend;

    localparam int CLK_PERIOD    = 100;
    localparam int HOLD_CYC      = 12;      // Stall length before commits are let go
    localparam int CYC_PER_ENTRY = 40;

    typedef enum logic [1:0] {RDY_ON, RDY_GAPS, RDY_HOLD} rdy_mode_t;

    // One row of the stimulus table
    typedef struct packed {
        logic [2:0]                 test;
        logic                       flush;      // Flush the back end before this row
        rdy_mode_t                  mode;       // comm_ready_i pattern while offered
        backend_pkg::issue_req_t    req;
    } stim_t;

    logic                       clk_i = 1'b0;
    logic                       rst_n_i, flush_i, issue_valid_i, issue_ready_o;
    logic                       comm_valid_o, comm_ready_i;
    backend_pkg::issue_req_t    issue_i;
    backend_pkg::commit_t       comm_o;
    stim_t                      stim [$];
    logic [31:0]                rng_q = 32'd82951;     // xorshift state
    int                         pend, err_cnt, comm_cnt, last_errs, tests_done;

    always #(CLK_PERIOD/2) clk_i = ~clk_i;

    ooo_backend dut0 (
        .clk_i, .rst_n_i, .flush_i,
        .issue_valid_i, .issue_ready_o, .issue_i,
        .comm_valid_o, .comm_ready_i, .comm_o
    );

    commit_checker chk0 (
        .clk_i, .rst_n_i, .flush_i, .issue_valid_i,
        .issue_ready_i (issue_ready_o),
        .issue_i,
        .comm_valid_i  (comm_valid_o),
        .comm_ready_i,
        .comm_i        (comm_o),
        .pend_o        (pend),
        .err_cnt_o     (err_cnt),
        .comm_cnt_o    (comm_cnt)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    task automatic add_row(input int t, input logic fl, input rdy_mode_t m,
                           input logic [3:0] op, rd, rs1, rs2, input logic [15:0] imm);
        stim_t r;
        r.test          = t[2:0];
        r.flush         = fl;
        r.mode          = m;
        r.req.instr.op  = isa_pkg::opcode_t'(op);
        r.req.instr.rd  = rd;
        r.req.instr.rs1 = rs1;
        r.req.instr.rs2 = rs2;
        r.req.instr.imm = imm;
        r.req.pc        = 32'h0000_0100 + 32'(stim.size() * 4);   // Word-aligned program
        stim.push_back(r);
    endtask

    // ------------------------------------------------------------------------
    // Stimulus table
    // ------------------------------------------------------------------------
    task automatic build_table();
        add_row(1, 0, RDY_ON,   isa_pkg::OP_LI,   4'd1,  4'd0,  4'd0,  16'd5);
        add_row(1, 0, RDY_ON,   isa_pkg::OP_LI,   4'd2,  4'd0,  4'd0,  16'hFFFD);
        add_row(1, 0, RDY_ON,   isa_pkg::OP_ADD,  4'd3,  4'd1,  4'd2,  16'd0);
        add_row(1, 0, RDY_ON,   isa_pkg::OP_SUB,  4'd4,  4'd1,  4'd2,  16'd0);
        add_row(1, 0, RDY_ON,   isa_pkg::OP_XOR,  4'd5,  4'd1,  4'd2,  16'd0);
        add_row(1, 0, RDY_ON,   isa_pkg::OP_ADDI, 4'd6,  4'd1,  4'd0,  16'd100);
        add_row(1, 0, RDY_ON,   isa_pkg::OP_ADD,  4'd0,  4'd1,  4'd1,  16'd0);   // r0 sink
        add_row(1, 0, RDY_ON,   isa_pkg::OP_ADD,  4'd7,  4'd0,  4'd1,  16'd0);
        // Chains through pending products
        add_row(2, 0, RDY_GAPS, isa_pkg::OP_MUL,  4'd8,  4'd1,  4'd4,  16'd0);
        add_row(2, 0, RDY_GAPS, isa_pkg::OP_ADD,  4'd9,  4'd8,  4'd1,  16'd0);
        add_row(2, 0, RDY_GAPS, isa_pkg::OP_MUL,  4'd10, 4'd9,  4'd9,  16'd0);
        add_row(2, 0, RDY_GAPS, isa_pkg::OP_SUB,  4'd11, 4'd10, 4'd8,  16'd0);
        add_row(2, 0, RDY_GAPS, isa_pkg::OP_ADDI, 4'd12, 4'd11, 4'd0,  16'hFFFF);
        add_row(3, 0, RDY_GAPS, isa_pkg::OP_MUL,  4'd1,  4'd3,  4'd4,  16'd0);
        add_row(3, 0, RDY_GAPS, isa_pkg::OP_ADD,  4'd2,  4'd5,  4'd6,  16'd0);
        add_row(3, 0, RDY_GAPS, isa_pkg::OP_XOR,  4'd3,  4'd6,  4'd7,  16'd0);
        add_row(3, 0, RDY_GAPS, isa_pkg::OP_MUL,  4'd4,  4'd4,  4'd4,  16'd0);
        add_row(3, 0, RDY_GAPS, isa_pkg::OP_ADDI, 4'd5,  4'd5,  4'd0,  16'd7);
        add_row(3, 0, RDY_GAPS, isa_pkg::OP_SUB,  4'd6,  4'd1,  4'd2,  16'd0);
        add_row(4, 0, RDY_ON,   isa_pkg::OP_LI,   4'd13, 4'd0,  4'd0,  16'h1234);
        add_row(4, 0, RDY_ON,   4'hF,             4'd13, 4'd0,  4'd0,  16'hBEEF);  // Illegal
        add_row(4, 0, RDY_ON,   isa_pkg::OP_ADD,  4'd14, 4'd13, 4'd0,  16'd0);
        for (int k = 1; k <= 10; k++)                   // More rows than ROB entries
            add_row(5, 0, RDY_HOLD, isa_pkg::OP_LI, 4'(k), 4'd0, 4'd0, 16'(k * 3));
        add_row(5, 0, RDY_ON,   isa_pkg::OP_ADD,  4'd11, 4'd1,  4'd10, 16'd0);
        add_row(5, 0, RDY_ON,   isa_pkg::OP_MUL,  4'd12, 4'd9,  4'd10, 16'd0);
        add_row(6, 0, RDY_ON,   isa_pkg::OP_MUL,  4'd15, 4'd1,  4'd1,  16'd0);
        add_row(6, 0, RDY_ON,   isa_pkg::OP_LI,   4'd14, 4'd0,  4'd0,  16'd99);
        add_row(6, 1, RDY_ON,   isa_pkg::OP_ADD,  4'd13, 4'd14, 4'd14, 16'd0);
        add_row(6, 0, RDY_ON,   isa_pkg::OP_MUL,  4'd12, 4'd13, 4'd2,  16'd0);
    endtask

    task automatic drive_ready(input rdy_mode_t m, input int stall);
        rng_q = xorshift32(rng_q);
        case (m)
            RDY_ON:   comm_ready_i <= 1'b1;
            RDY_GAPS: comm_ready_i <= (rng_q[1:0] != 2'b00);    // Roughly one gap in four
            default:  comm_ready_i <= (stall >= HOLD_CYC);
        endcase
    endtask

    // Hold the row on the issue port until it is taken
    task automatic offer(input stim_t s);
        int stall;
        stall = 0;
        issue_valid_i <= 1'b1;
        issue_i       <= s.req;
        drive_ready(s.mode, stall);
        @(posedge clk_i);
        while (!issue_ready_o) begin
            stall++;
            drive_ready(s.mode, stall);
            @(posedge clk_i);
        end
    endtask

    task automatic flush_pipe();
        issue_valid_i <= 1'b0;
        comm_ready_i  <= 1'b0;
        flush_i       <= 1'b1;
        @(posedge clk_i);
        flush_i       <= 1'b0;
    endtask

    task automatic finish_test(input int t);
        issue_valid_i <= 1'b0;
        do begin
            drive_ready(RDY_GAPS, 0);
            @(posedge clk_i);
        end while (pend != 0);                          // Wait for the ROB to drain
        tests_done++;
        $display("Test %0d finished: %0d commits so far, %0d new errors",
                 t, comm_cnt, err_cnt - last_errs);
        last_errs = err_cnt;
    endtask

    initial begin
        rst_n_i       = 1'b0;
        flush_i       = 1'b0;
        issue_valid_i = 1'b0;
        issue_i       = '0;
        comm_ready_i  = 1'b0;
        last_errs     = 0;
        tests_done    = 0;
        build_table();
        repeat (2) @(posedge clk_i);
        rst_n_i <= 1'b1;
        foreach (stim[i]) begin
            if (i > 0 && stim[i].test != stim[i-1].test)
                finish_test(stim[i-1].test);
            if (stim[i].flush)
                flush_pipe();
            offer(stim[i]);
        end
        finish_test(stim[stim.size()-1].test);
        $display("Summary: %0d tests, %0d commits, %0d errors", tests_done, comm_cnt, err_cnt);
        if (err_cnt == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

    // Watchdog scaled by the table length
    initial begin
        #(CLK_PERIOD);
        #(stim.size() * CYC_PER_ENTRY * CLK_PERIOD);
        $display("Timeout: the run did not finish within %0d cycles",
                 stim.size() * CYC_PER_ENTRY);
        $display("Done: errors found");
        $finish;
    end

endmodule
